// File: Makefile
TOP := cdbus_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module $(TOP) \
		-f verilog.f -o $(TOP)

# the assertion error limit keeps the run going so the testbench can print its verdict
run: compile
	./obj_dir/$(TOP) +verilator+error+limit+100 | tee /dev/stderr | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir

// File: design/cd_csr.sv
/*
 * Host register block:
 *   address decode, filter and interrupt mask registers,
 *   transmit buffer write pointer, receive buffer read pointer,
 *   sticky error flags, status word and registered irq.
 */
`timescale 1ns/1ps

module cd_csr (
    input  logic                 clk,
    input  logic                 arst_n,
    input  cdbus_pkg::csr_addr_e csr_address,
    input  logic                 csr_read,
    input  logic                 csr_write,
    input  logic [7:0]           csr_writedata,
    output logic [7:0]           csr_readdata,
    output logic                 irq,
    output logic [7:0]           filter,
    output logic                 tx_wr_en,
    output cdbus_pkg::buf_addr_t tx_wr_addr,
    output logic [7:0]           tx_wr_byte,
    output logic                 tx_commit,
    input  logic                 tx_full,
    output cdbus_pkg::buf_addr_t rx_rd_addr,
    output logic                 rx_release,
    input  logic [7:0]           rx_rd_byte,
    input  logic                 rx_full,
    input  logic                 rx_crc_err,
    input  logic                 rx_lost
);
    import cdbus_pkg::*;

    buf_addr_t  tx_ptr;
    buf_addr_t  rx_ptr;
    logic [7:0] int_mask;
    logic [7:0] rd_reg;
    logic       rd_sel_rx;
    logic       err_flag;
    logic       lost_flag;
    logic       rx_pop;
    logic       ctrl_wr;
    logic       clr_err;
    logic [7:0] status;

    assign status     = {4'd0, lost_flag, err_flag, tx_full, rx_full};
    assign ctrl_wr    = csr_write && csr_address == ADDR_CTRL;
    assign rx_pop     = csr_read && csr_address == ADDR_RX_DATA;
    assign tx_wr_en   = csr_write && csr_address == ADDR_TX_DATA && !tx_full;
    assign tx_wr_addr = tx_ptr;
    assign tx_wr_byte = csr_writedata;
    assign tx_commit  = ctrl_wr && csr_writedata[0] && !tx_full;  // pointer value is the length
    assign rx_release = ctrl_wr && csr_writedata[1];
    assign clr_err    = ctrl_wr && csr_writedata[2];

    // between pops the RAM keeps presenting the byte just popped
    assign rx_rd_addr   = rx_pop ? rx_ptr : rx_ptr - 8'd1;
    assign csr_readdata = rd_sel_rx ? rx_rd_byte : rd_reg;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tx_ptr    <= '0;
            rx_ptr    <= '0;
            filter    <= '0;
            int_mask  <= '0;
            rd_reg    <= '0;
            rd_sel_rx <= 1'b0;
            err_flag  <= 1'b0;
            lost_flag <= 1'b0;
            irq       <= 1'b0;
        end else begin
            if (tx_commit) begin
                tx_ptr <= '0;
            end else if (tx_wr_en) begin
                tx_ptr <= tx_ptr + 8'd1;
            end
            if (rx_release) begin
                rx_ptr <= '0;
            end else if (rx_pop) begin
                rx_ptr <= rx_ptr + 8'd1;
            end
            if (csr_write && csr_address == ADDR_FILTER) begin
                filter <= csr_writedata;
            end
            if (csr_write && csr_address == ADDR_INT_MASK) begin
                int_mask <= csr_writedata;
            end
            if (rx_crc_err) begin
                err_flag <= 1'b1;
            end else if (clr_err) begin
                err_flag <= 1'b0;
            end
            if (rx_lost) begin
                lost_flag <= 1'b1;
            end else if (clr_err) begin
                lost_flag <= 1'b0;
            end
            if (csr_read) begin
                rd_sel_rx <= rx_pop;
                case (csr_address)
                    ADDR_FILTER:   rd_reg <= filter;
                    ADDR_STATUS:   rd_reg <= status;
                    ADDR_INT_MASK: rd_reg <= int_mask;
                    default:       rd_reg <= 8'h00;
                endcase
            end
            irq <= |(status & int_mask);
        end
    end

endmodule

// File: design/cd_frame_ram.sv
/*
 * One-frame byte buffer:
 *   256 x 8 storage with registered read,
 *   full flag set by commit and cleared by release, stored length.
 */
`timescale 1ns/1ps

module cd_frame_ram (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 wr_en,
    input  cdbus_pkg::buf_addr_t wr_addr,
    input  logic [7:0]           wr_byte,
    input  logic                 commit,
    input  cdbus_pkg::buf_addr_t wr_len,
    input  cdbus_pkg::buf_addr_t rd_addr,
    output logic [7:0]           rd_byte,
    input  logic                 release_frame,
    output logic                 full,
    output cdbus_pkg::buf_addr_t len
);
    logic [7:0] mem [256];

    always_ff @(posedge clk) begin
        if (wr_en && !full) begin
            mem[wr_addr] <= wr_byte;  // a held frame is never overwritten
        end
        rd_byte <= mem[rd_addr];
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            full <= 1'b0;
            len  <= '0;
        end else if (release_frame) begin
            full <= 1'b0;
        end else if (commit && !full) begin
            full <= 1'b1;
            len  <= wr_len;
        end
    end

endmodule

// File: design/cd_rx_bytes.sv
/*
 * Receive frame assembly:
 *   byte counting and buffer writes, destination filter,
 *   CRC residue and length check, commit or error at frame end.
 */
`timescale 1ns/1ps

module cd_rx_bytes (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic [7:0]           filter,
    input  cdbus_pkg::rx_byte_t  rx_byte,
    input  logic                 rx_valid,
    output logic                 ram_wr_en,
    output cdbus_pkg::buf_addr_t ram_wr_addr,
    output logic [7:0]           ram_wr_byte,
    output logic                 ram_commit,
    output cdbus_pkg::buf_addr_t ram_wr_len,
    input  logic                 ram_full,
    output logic                 crc_err,
    output logic                 lost
);
    import cdbus_pkg::*;

    logic [8:0]  cnt;
    logic [15:0] crc;
    logic        match;
    buf_addr_t   len_field;
    logic        data_in;
    logic        frame_done;
    logic        good;

    assign data_in     = rx_valid && !rx_byte.frame_end;
    assign frame_done  = rx_valid && rx_byte.frame_end;
    assign ram_wr_en   = data_in && !cnt[8];
    assign ram_wr_addr = cnt[7:0];
    assign ram_wr_byte = rx_byte.data;
    // header of three, data, then two CRC bytes
    assign good = crc == 16'h0000 && cnt == {1'b0, len_field} + 9'd5;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt        <= '0;
            crc        <= 16'hFFFF;
            match      <= 1'b0;
            len_field  <= '0;
            ram_commit <= 1'b0;
            ram_wr_len <= '0;
            crc_err    <= 1'b0;
            lost       <= 1'b0;
        end else begin
            ram_commit <= 1'b0;
            crc_err    <= 1'b0;
            lost       <= 1'b0;
            if (data_in) begin
                cnt <= (cnt == 9'h1FF) ? cnt : cnt + 9'd1;
                crc <= crc16_step(crc, rx_byte.data);
                if (cnt == 9'd1) begin
                    match <= rx_byte.data == filter || rx_byte.data == 8'hFF;
                end
                if (cnt == 9'd2) begin
                    len_field <= rx_byte.data;
                end
            end else if (frame_done) begin
                cnt   <= '0;
                crc   <= 16'hFFFF;
                match <= 1'b0;
                if (match && good) begin
                    ram_commit <= !ram_full;
                    lost       <= ram_full;
                    ram_wr_len <= len_field + 8'd3;
                end else if (match) begin
                    crc_err <= 1'b1;  // frames for other nodes are dropped silently
                end
            end
        end
    end

endmodule

// File: design/cd_rx_des.sv
/*
 * Receive deserializer:
 *   two-stage input synchronizer, start-bit detection,
 *   mid-bit sampling with stop-bit check, idle frame-end detection.
 */
`timescale 1ns/1ps

module cd_rx_des #(
    parameter int DIV       = 8,
    parameter int IDLE_BITS = 2
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                rx,
    output cdbus_pkg::rx_byte_t rx_byte,
    output logic                rx_valid
);
    localparam int TW   = $clog2(DIV);
    localparam int IDLE = IDLE_BITS * DIV;
    localparam int IW   = $clog2(IDLE + 1);

    logic [1:0]    rx_sync;
    logic          rx_in;
    logic          rx_prev;
    logic          busy;
    logic [TW-1:0] tim;
    logic [3:0]    bit_cnt;
    logic [7:0]    shift;
    logic          sample;
    logic          stop_ok;
    logic [IW-1:0] idle_cnt;
    logic          in_frame;
    logic          idle_hit;

    assign rx_in    = rx_sync[1];
    assign sample   = busy && tim == TW'(DIV / 2);
    assign stop_ok  = sample && bit_cnt == 4'd9 && rx_in;
    assign idle_hit = in_frame && !busy && idle_cnt == IW'(IDLE);

    always_ff @(posedge clk) begin
        if (sample && bit_cnt != 4'd0 && bit_cnt != 4'd9) begin
            shift <= {rx_in, shift[7:1]};  // lsb arrives first
        end
        if (stop_ok) begin
            rx_byte <= '{data: shift, frame_end: 1'b0};
        end else if (idle_hit) begin
            rx_byte <= '{data: 8'h00, frame_end: 1'b1};
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rx_sync  <= 2'b11;
            rx_prev  <= 1'b1;
            busy     <= 1'b0;
            tim      <= '0;
            bit_cnt  <= '0;
            idle_cnt <= '0;
            in_frame <= 1'b0;
            rx_valid <= 1'b0;
        end else begin
            rx_sync  <= {rx_sync[0], rx};
            rx_prev  <= rx_in;
            rx_valid <= stop_ok || idle_hit;
            if (stop_ok) begin
                in_frame <= 1'b1;
            end else if (idle_hit) begin
                in_frame <= 1'b0;  // one frame_end per frame
            end
            if (busy || !rx_in) begin
                idle_cnt <= '0;
            end else if (idle_cnt != IW'(IDLE)) begin
                idle_cnt <= idle_cnt + 1'b1;
            end
            if (!busy) begin
                if (rx_prev && !rx_in) begin
                    busy    <= 1'b1;
                    tim     <= TW'(1);
                    bit_cnt <= '0;
                end
            end else begin
                tim <= (tim == TW'(DIV - 1)) ? '0 : tim + 1'b1;
                if (sample) begin
                    bit_cnt <= bit_cnt + 4'd1;
                    if ((bit_cnt == 4'd0 && rx_in) || bit_cnt == 4'd9) begin
                        busy <= 1'b0;  // false start or byte done
                    end
                end
            end
        end
    end

endmodule

// File: design/cd_tx_bytes.sv
/*
 * Transmit byte feeder:
 *   walks the transmit buffer, folds each byte into the CRC,
 *   appends CRC low and high bytes and hands bytes to the
 *   serializer under a credit count.
 */
`timescale 1ns/1ps

module cd_tx_bytes (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   ram_full,
    input  cdbus_pkg::buf_addr_t   ram_len,
    input  logic [7:0]             ram_rd_byte,
    output cdbus_pkg::buf_addr_t   ram_rd_addr,
    output logic                   ram_release,
    output cdbus_pkg::frame_byte_t ser_byte,
    output logic                   ser_valid,
    input  logic                   credit_return
);
    import cdbus_pkg::*;

    typedef enum logic [2:0] {ST_IDLE, ST_FETCH, ST_DATA, ST_CRC_LO, ST_CRC_HI} state_e;

    state_e      state;
    buf_addr_t   idx;
    logic [15:0] crc;
    logic [1:0]  credits;
    logic        sending;

    assign sending     = state == ST_DATA || state == ST_CRC_LO || state == ST_CRC_HI;
    assign ser_valid   = sending && credits != 2'd0;
    assign ram_rd_addr = idx;
    assign ram_release = ser_valid && state == ST_CRC_HI;  // frees the buffer as idle is entered

    always_comb begin
        ser_byte.last = state == ST_CRC_HI;
        case (state)
            ST_CRC_LO: ser_byte.data = crc[7:0];
            ST_CRC_HI: ser_byte.data = crc[15:8];
            default:   ser_byte.data = ram_rd_byte;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= ST_IDLE;
            idx     <= '0;
            crc     <= 16'hFFFF;
            credits <= 2'(TX_CREDITS);
        end else begin
            case ({ser_valid, credit_return})
                2'b10:   credits <= credits - 2'd1;
                2'b01:   credits <= credits + 2'd1;
                default: credits <= credits;
            endcase
            case (state)
                ST_IDLE: begin
                    idx <= '0;
                    crc <= 16'hFFFF;
                    if (ram_full) begin
                        state <= (ram_len == 8'd0) ? ST_CRC_LO : ST_FETCH;
                    end
                end
                ST_FETCH: state <= ST_DATA;  // one cycle of RAM read latency
                ST_DATA: if (ser_valid) begin
                    crc   <= crc16_step(crc, ram_rd_byte);
                    idx   <= idx + 8'd1;
                    state <= (idx + 8'd1 == ram_len) ? ST_CRC_LO : ST_FETCH;
                end
                ST_CRC_LO: if (ser_valid) begin
                    state <= ST_CRC_HI;
                end
                ST_CRC_HI: if (ser_valid) begin
                    state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// File: design/cd_tx_ser.sv
/*
 * Transmit serializer:
 *   two-entry byte queue returning one credit per pop,
 *   bit timer, ten-bit start/data/stop shifter and tx_en.
 */
`timescale 1ns/1ps

module cd_tx_ser #(
    parameter int DIV = 8
) (
    input  logic                   clk,
    input  logic                   arst_n,
    input  cdbus_pkg::frame_byte_t ser_byte,
    input  logic                   ser_valid,
    output logic                   credit_return,
    output logic                   tx,
    output logic                   tx_en
);
    import cdbus_pkg::*;

    localparam int TW = $clog2(DIV);

    frame_byte_t   queue [TX_CREDITS];
    logic          wr_ptr;
    logic          rd_ptr;
    logic [1:0]    count;
    logic          busy;
    logic          cur_last;
    logic [9:0]    shift;
    logic [TW-1:0] tim;
    logic [3:0]    bit_cnt;
    logic          bit_end;
    logic          byte_end;
    logic          pop;

    assign bit_end       = busy && tim == TW'(DIV - 1);
    assign byte_end      = bit_end && bit_cnt == 4'd9;
    assign pop           = count != 2'd0 && (!busy || byte_end);  // next byte starts back to back
    assign credit_return = pop;
    assign tx            = busy ? shift[0] : 1'b1;

    always_ff @(posedge clk) begin
        if (ser_valid) begin
            queue[wr_ptr] <= ser_byte;
        end
        if (pop) begin
            shift <= {1'b1, queue[rd_ptr].data, 1'b0};
        end else if (bit_end) begin
            shift <= {1'b1, shift[9:1]};
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr   <= 1'b0;
            rd_ptr   <= 1'b0;
            count    <= '0;
            busy     <= 1'b0;
            cur_last <= 1'b0;
            tim      <= '0;
            bit_cnt  <= '0;
            tx_en    <= 1'b0;
        end else begin
            wr_ptr <= wr_ptr ^ ser_valid;
            rd_ptr <= rd_ptr ^ pop;
            case ({ser_valid, pop})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: count <= count;
            endcase
            if (pop) begin
                busy     <= 1'b1;
                cur_last <= queue[rd_ptr].last;
                tim      <= '0;
                bit_cnt  <= '0;
                tx_en    <= 1'b1;
            end else if (byte_end) begin
                busy <= 1'b0;
                if (cur_last) begin
                    tx_en <= 1'b0;  // end of the final stop bit
                end
            end else if (bit_end) begin
                tim     <= '0;
                bit_cnt <= bit_cnt + 4'd1;
            end else if (busy) begin
                tim <= tim + 1'b1;
            end
        end
    end

endmodule

// File: design/cdbus.sv
/*
 * CDBUS controller top level:
 *   register block, transmit and receive frame buffers,
 *   transmit byte feeder and serializer, receive deserializer
 *   and frame assembly.
 */
`timescale 1ns/1ps

module cdbus #(
    parameter int DIV       = 8,
    parameter int IDLE_BITS = 2
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  cdbus_pkg::csr_addr_e csr_address,
    input  logic                 csr_read,
    input  logic                 csr_write,
    input  logic [7:0]           csr_writedata,
    output logic [7:0]           csr_readdata,
    output logic                 irq,
    input  logic                 rx,
    output logic                 tx,
    output logic                 tx_en
);
    import cdbus_pkg::*;

    logic [7:0]  filter;
    logic        tx_wr_en;
    buf_addr_t   tx_wr_addr;
    logic [7:0]  tx_wr_byte;
    logic        tx_commit;
    logic        tx_full;
    buf_addr_t   tx_len;
    buf_addr_t   tx_rd_addr;
    logic [7:0]  tx_rd_byte;
    logic        tx_release;
    frame_byte_t ser_byte;
    logic        ser_valid;
    logic        credit_return;
    rx_byte_t    rx_byte;
    logic        rx_valid;
    logic        rx_wr_en;
    buf_addr_t   rx_wr_addr;
    logic [7:0]  rx_wr_byte;
    logic        rx_commit;
    buf_addr_t   rx_wr_len;
    logic        rx_full;
    buf_addr_t   rx_rd_addr;
    logic [7:0]  rx_rd_byte;
    logic        rx_release;
    logic        rx_crc_err;
    logic        rx_lost;

    cd_csr cd_csr_i (
        .clk, .arst_n, .csr_address, .csr_read, .csr_write, .csr_writedata, .csr_readdata,
        .irq, .filter, .tx_wr_en, .tx_wr_addr, .tx_wr_byte, .tx_commit, .tx_full,
        .rx_rd_addr, .rx_release, .rx_rd_byte, .rx_full, .rx_crc_err, .rx_lost
    );

    // tx_ram length is the write pointer at the start command
    cd_frame_ram tx_ram (
        .clk, .arst_n, .wr_en(tx_wr_en), .wr_addr(tx_wr_addr), .wr_byte(tx_wr_byte),
        .commit(tx_commit), .wr_len(tx_wr_addr), .rd_addr(tx_rd_addr), .rd_byte(tx_rd_byte),
        .release_frame(tx_release), .full(tx_full), .len(tx_len)
    );

    cd_frame_ram rx_ram (
        .clk, .arst_n, .wr_en(rx_wr_en), .wr_addr(rx_wr_addr), .wr_byte(rx_wr_byte),
        .commit(rx_commit), .wr_len(rx_wr_len), .rd_addr(rx_rd_addr), .rd_byte(rx_rd_byte),
        .release_frame(rx_release), .full(rx_full), .len()
    );

    cd_tx_bytes cd_tx_bytes_i (
        .clk, .arst_n, .ram_full(tx_full), .ram_len(tx_len), .ram_rd_byte(tx_rd_byte),
        .ram_rd_addr(tx_rd_addr), .ram_release(tx_release),
        .ser_byte, .ser_valid, .credit_return
    );

    cd_tx_ser #(.DIV(DIV)) cd_tx_ser_i (
        .clk, .arst_n, .ser_byte, .ser_valid, .credit_return, .tx, .tx_en
    );

    cd_rx_des #(.DIV(DIV), .IDLE_BITS(IDLE_BITS)) cd_rx_des_i (
        .clk, .arst_n, .rx, .rx_byte, .rx_valid
    );

    cd_rx_bytes cd_rx_bytes_i (
        .clk, .arst_n, .filter, .rx_byte, .rx_valid,
        .ram_wr_en(rx_wr_en), .ram_wr_addr(rx_wr_addr), .ram_wr_byte(rx_wr_byte),
        .ram_commit(rx_commit), .ram_wr_len(rx_wr_len), .ram_full(rx_full),
        .crc_err(rx_crc_err), .lost(rx_lost)
    );

endmodule

// File: design/cdbus_pkg.sv
/*
 * Shared CDBUS definitions:
 *   buffer address type, transmit and receive byte structs,
 *   register address map, serializer credit depth and the
 *   CRC-16 (MODBUS) byte step.
 */
package cdbus_pkg;

    typedef logic [7:0] buf_addr_t;

    typedef struct packed {
        logic [7:0] data;
        logic       last;       // high on the CRC high byte
    } frame_byte_t;

    typedef struct packed {
        logic [7:0] data;
        logic       frame_end;  // idle seen, data is not meaningful
    } rx_byte_t;

    typedef enum logic [3:0] {
        ADDR_FILTER   = 4'd1,
        ADDR_TX_DATA  = 4'd2,
        ADDR_RX_DATA  = 4'd3,
        ADDR_CTRL     = 4'd4,
        ADDR_STATUS   = 4'd5,
        ADDR_INT_MASK = 4'd6
    } csr_addr_e;

    localparam int TX_CREDITS = 2;

    // reflected polynomial A001, one byte per call
    function automatic logic [15:0] crc16_step(input logic [15:0] crc, input logic [7:0] data);
        logic [15:0] c;
        c = crc ^ {8'h00, data};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ 16'hA001) : (c >> 1);
        end
        return c;
    endfunction

endpackage

// File: dv/cdbus_properties.sv
/*
 * Bound checks on the CDBUS top level:
 *   idle line level, credit count bound and room in the
 *   serializer queue, tx_en and irq right after reset.
 */
`timescale 1ns/1ps

module cdbus_properties (
    input logic       clk,
    input logic       arst_n,
    input logic       tx,
    input logic       tx_en,
    input logic       irq,
    input logic       ser_valid,
    input logic [1:0] credits,
    input logic [1:0] queue_count
);
    import cdbus_pkg::*;

    int assert_fails = 0;  // read by the testbench at the end of the run

    a_idle_high: assert property (@(posedge clk) disable iff (!arst_n) !tx_en |-> tx)
        else begin
            $error("tx low while tx_en is low");
            assert_fails++;
        end

    a_credit_max: assert property (@(posedge clk) disable iff (!arst_n)
        credits <= 2'(TX_CREDITS))
        else begin
            $error("credit count above the serializer queue depth");
            assert_fails++;
        end

    // a spent credit must always match a free slot in the serializer queue
    a_credit_spend: assert property (@(posedge clk) disable iff (!arst_n)
        ser_valid |-> queue_count < 2'(TX_CREDITS))
        else begin
            $error("byte offered while the serializer queue is full");
            assert_fails++;
        end

    a_reset_out: assert property (@(posedge clk) $rose(arst_n) |-> !tx_en && !irq)
        else begin
            $error("tx_en or irq high in the first cycle after reset");
            assert_fails++;
        end

endmodule

bind cdbus cdbus_properties cdbus_properties_i (
    .clk, .arst_n, .tx, .tx_en, .irq, .ser_valid, .credits(cd_tx_bytes_i.credits),
    .queue_count(cd_tx_ser_i.count)
);

// File: dv/cdbus_tb.sv
/*
 * CDBUS controller testbench:
 *   clock, reset, host register tasks, tx line monitor,
 *   bit-level rx line driver, reference CRC, compare process,
 *   directed frame tests and watchdog.
 */
`timescale 1ns/1ps

module cdbus_tb;
    import cdbus_pkg::*;

    localparam int     DIV         = 8;
    localparam int     IDLE_BITS   = 2;
    localparam int     CLK_NS      = 40;
    localparam int     N_FRAMES    = 7;
    localparam int     MAX_FRAME   = 17;  // header, 12 data bytes and the CRC
    localparam int     FRAME_CYC   = (MAX_FRAME + 4) * 10 * DIV;
    localparam longint WATCHDOG_NS = 2 * N_FRAMES * FRAME_CYC * CLK_NS;

    logic       clk;
    logic       arst_n;
    csr_addr_e  csr_address;
    logic       csr_read;
    logic       csr_write;
    logic [7:0] csr_writedata;
    logic [7:0] csr_readdata;
    logic       irq;
    logic       rx;
    logic       tx;
    logic       tx_en;
    logic       use_drv;
    logic       drv_line;
    int         seed = 32'hc8f20a7e;
    int         errors;
    int         err_base;
    int         pass_count;
    int         fail_count;
    string      test_name;
    logic [7:0] frame_q [$];
    logic [7:0] first_q [$];
    logic [7:0] tx_seen [$];
    logic [7:0] exp_q [$];
    logic [7:0] act_q [$];
    string      name_q [$];

    assign rx = use_drv ? drv_line : tx;  // loopback unless the driver owns the line

    cdbus #(.DIV(DIV), .IDLE_BITS(IDLE_BITS)) cdbus_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    // serial form of the reflected CRC over the current frame bytes
    function automatic logic [15:0] crc16_ref();
        logic [15:0] r;
        logic        fb;
        r = 16'hFFFF;
        foreach (frame_q[i]) begin
            for (int b = 0; b < 8; b++) begin
                fb = r[0] ^ frame_q[i][b];
                r  = fb ? ({1'b0, r[15:1]} ^ 16'hA001) : {1'b0, r[15:1]};
            end
        end
        return r;
    endfunction

    function automatic logic accept_ref(input logic [7:0] dst, input logic [7:0] filt);
        return dst == filt || dst == 8'hFF;
    endfunction

    always @(posedge clk) begin
        while (act_q.size() > 0) begin
            if (act_q[0] !== exp_q[0]) begin
                $display("ERR %s: expected %02h, actual %02h", name_q[0], exp_q[0], act_q[0]);
                errors++;
            end
            act_q.delete(0);
            exp_q.delete(0);
            name_q.delete(0);
        end
    end

    // decodes bytes from tx at mid-bit
    initial begin
        logic [7:0] b;
        forever begin
            @(negedge clk);
            if (tx_en && !tx) begin
                repeat (DIV / 2) @(negedge clk);
                for (int k = 0; k < 8; k++) begin
                    repeat (DIV) @(negedge clk);
                    b[k] = tx;
                end
                repeat (DIV) @(negedge clk);
                tx_seen.push_back(b);
            end
        end
    end

    task automatic check(input string what, input logic [7:0] exp, input logic [7:0] act);
        name_q.push_back({test_name, " ", what});
        exp_q.push_back(exp);
        act_q.push_back(act);
    endtask

    task automatic reg_write(input csr_addr_e addr, input logic [7:0] data);
        @(negedge clk);
        csr_address   = addr;
        csr_writedata = data;
        csr_write     = 1'b1;
        @(negedge clk);
        csr_write = 1'b0;
    endtask

    task automatic reg_read(input csr_addr_e addr, output logic [7:0] data);
        @(negedge clk);
        csr_address = addr;
        csr_read    = 1'b1;
        @(negedge clk);
        csr_read = 1'b0;
        data     = csr_readdata;
    endtask

    task automatic build_frame(input logic [7:0] dst);
        int n;
        n       = 1 + int'($unsigned($random(seed)) % 12);
        frame_q = {};
        frame_q.push_back(8'($random(seed)));
        frame_q.push_back(dst);
        frame_q.push_back(8'(n));
        repeat (n) begin
            frame_q.push_back(8'($random(seed)));
        end
    endtask

    task automatic send_frame();
        tx_seen = {};
        foreach (frame_q[i]) begin
            reg_write(ADDR_TX_DATA, frame_q[i]);
        end
        reg_write(ADDR_CTRL, 8'h01);
    endtask

    task automatic wait_tx_done();
        bit seen;
        int n;
        seen = 1'b0;
        n    = 0;
        while (!(seen && !tx_en) && n < FRAME_CYC) begin
            @(negedge clk);
            seen = seen | tx_en;
            n++;
        end
        if (!(seen && !tx_en)) begin
            $display("%s: tx_en did not finish a frame in time", test_name);
            errors++;
        end
        repeat ((IDLE_BITS + 2) * DIV) @(negedge clk);
    endtask

    task automatic wait_rx_pending();
        logic [7:0] st;
        int         n;
        st = 8'h00;
        n  = 0;
        while (!st[0] && n < FRAME_CYC) begin
            reg_read(ADDR_STATUS, st);
            n += 2;
        end
        if (!st[0]) begin
            $display("%s: no received frame within the timeout", test_name);
            errors++;
        end
    endtask

    task automatic read_back();
        logic [7:0] b;
        foreach (frame_q[i]) begin
            reg_read(ADDR_RX_DATA, b);
            check($sformatf("rx byte %0d", i), frame_q[i], b);
        end
    endtask

    task automatic drive_bit(input logic v);
        drv_line = v;
        repeat (DIV) @(negedge clk);
    endtask

    // sends frame_q and its CRC on rx with one bit inverted
    task automatic drive_frame(input int flip_byte, input int flip_bit);
        logic [15:0] crc;
        logic [7:0]  b;
        logic [7:0]  line_q [$];
        crc    = crc16_ref();
        line_q = frame_q;
        line_q.push_back(crc[7:0]);
        line_q.push_back(crc[15:8]);
        b                 = line_q[flip_byte];
        b[flip_bit]       = ~b[flip_bit];
        line_q[flip_byte] = b;
        @(negedge clk);
        use_drv = 1'b1;
        foreach (line_q[i]) begin
            b = line_q[i];
            drive_bit(1'b0);
            for (int k = 0; k < 8; k++) begin
                drive_bit(b[k]);
            end
            drive_bit(1'b1);
        end
        repeat ((IDLE_BITS + 2) * DIV) @(negedge clk);
        use_drv = 1'b0;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        err_base  = errors;
    endtask

    task automatic finish_test();
        @(posedge clk);
        @(negedge clk);
        if (errors == err_base) begin
            pass_count++;
            $display("%s: ok", test_name);
        end else begin
            fail_count++;
            $display("%s: %0d errors", test_name, errors - err_base);
        end
    endtask

    initial begin
        logic [7:0]  st;
        logic [15:0] crc;
        int          n;
        arst_n        = 1'b0;
        csr_address   = ADDR_STATUS;
        csr_read      = 1'b0;
        csr_write     = 1'b0;
        csr_writedata = 8'h00;
        use_drv       = 1'b0;
        drv_line      = 1'b1;
        errors        = 0;
        pass_count    = 0;
        fail_count    = 0;
        repeat (5) @(negedge clk);
        arst_n = 1'b1;

        start_test("reset");
        reg_read(ADDR_STATUS, st);
        check("status", 8'h00, st);
        check("irq", 8'h00, {7'd0, irq});
        check("tx_en", 8'h00, {7'd0, tx_en});
        finish_test();
        reg_write(ADDR_FILTER, 8'h5A);

        start_test("loopback");
        build_frame(8'h5A);
        send_frame();
        wait_rx_pending();
        reg_read(ADDR_STATUS, st);
        check("status", 8'h01, st);
        read_back();
        crc = crc16_ref();
        n   = frame_q.size();
        if (tx_seen.size() != n + 2) begin
            $display("%s: captured %0d bytes on tx, not %0d", test_name, tx_seen.size(), n + 2);
            errors++;
        end else begin
            check("crc low", crc[7:0], tx_seen[n]);
            check("crc high", crc[15:8], tx_seen[n + 1]);
        end
        reg_write(ADDR_CTRL, 8'h02);
        finish_test();

        start_test("filter");
        build_frame(8'hFF);
        send_frame();
        wait_tx_done();
        reg_read(ADDR_STATUS, st);
        check("broadcast status", {7'd0, accept_ref(8'hFF, 8'h5A)}, st);
        read_back();
        reg_write(ADDR_CTRL, 8'h02);
        build_frame(8'h33);
        send_frame();
        wait_tx_done();
        reg_read(ADDR_STATUS, st);
        check("other status", {7'd0, accept_ref(8'h33, 8'h5A)}, st);
        finish_test();

        start_test("bad crc");
        build_frame(8'h5A);
        drive_frame(3, int'($unsigned($random(seed)) % 8));  // first data byte
        reg_read(ADDR_STATUS, st);
        check("status", 8'h04, st);
        reg_write(ADDR_CTRL, 8'h04);
        reg_read(ADDR_STATUS, st);
        check("cleared status", 8'h00, st);
        finish_test();

        start_test("lost");
        build_frame(8'h5A);
        first_q = frame_q;
        send_frame();
        wait_rx_pending();
        build_frame(8'h5A);
        send_frame();
        wait_tx_done();
        reg_read(ADDR_STATUS, st);
        check("status", 8'h09, st);
        frame_q = first_q;
        read_back();
        reg_write(ADDR_CTRL, 8'h06);
        reg_read(ADDR_STATUS, st);
        check("cleared status", 8'h00, st);
        finish_test();

        start_test("irq");
        reg_write(ADDR_INT_MASK, 8'h01);
        build_frame(8'h5A);
        send_frame();
        wait_rx_pending();
        @(negedge clk);
        check("irq set", 8'h01, {7'd0, irq});
        reg_write(ADDR_CTRL, 8'h02);
        @(negedge clk);
        check("irq clear", 8'h00, {7'd0, irq});
        reg_write(ADDR_INT_MASK, 8'h00);
        finish_test();

        if (cdbus_i.cdbus_properties_i.assert_fails != 0) begin
            $display("bound assertions failed %0d times", cdbus_i.cdbus_properties_i.assert_fails);
            errors++;
        end
        $display("tests: %0d passed, %0d failed, %0d errors", pass_count, fail_count, errors);
        if (fail_count == 0 && errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns with tests still running", WATCHDOG_NS);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

// File: verilog.f
design/cdbus_pkg.sv
design/cd_frame_ram.sv
design/cd_csr.sv
design/cd_tx_bytes.sv
design/cd_tx_ser.sv
design/cd_rx_des.sv
design/cd_rx_bytes.sv
design/cdbus.sv
dv/cdbus_properties.sv
dv/cdbus_tb.sv
